/* logic/csr_pkg.sv */
// -------------------------------------------------------------------------
// Shared definitions of the machine-mode CSR block: data width, CSR
// addresses, array slots, bit positions, identity values, cause codes,
// the operation enum and the request, response, write-port and
// interrupt-status structs.
// -------------------------------------------------------------------------
`default_nettype none

package csr_pkg;

    localparam int XLEN = 64;

    // ---------------------------------------------------------------------
    // CSR addresses.
    // ---------------------------------------------------------------------
    localparam logic [11:0] ADDR_MSTATUS   = 12'h300;
    localparam logic [11:0] ADDR_MIE       = 12'h304;
    localparam logic [11:0] ADDR_MTVEC     = 12'h305;
    localparam logic [11:0] ADDR_MSCRATCH  = 12'h340;
    localparam logic [11:0] ADDR_MEPC      = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE    = 12'h342;
    localparam logic [11:0] ADDR_MIP       = 12'h344;
    localparam logic [11:0] ADDR_MVENDORID = 12'hF11;
    localparam logic [11:0] ADDR_MARCHID   = 12'hF12;
    localparam logic [11:0] ADDR_MIMPID    = 12'hF13;
    localparam logic [11:0] ADDR_MHARTID   = 12'hF14;

    // Slots of the writable array. Slot 1 is reserved.
    localparam logic [2:0] SLOT_MSTATUS  = 3'd0;
    localparam logic [2:0] SLOT_MIE      = 3'd2;
    localparam logic [2:0] SLOT_MTVEC    = 3'd3;
    localparam logic [2:0] SLOT_MCAUSE   = 3'd4;
    localparam logic [2:0] SLOT_MEPC     = 3'd5;
    localparam logic [2:0] SLOT_MIP      = 3'd6;
    localparam logic [2:0] SLOT_MSCRATCH = 3'd7;

    // Slots of the read-only identity registers.
    localparam logic [1:0] RO_MHARTID   = 2'd0;
    localparam logic [1:0] RO_MVENDORID = 2'd1;
    localparam logic [1:0] RO_MARCHID   = 2'd2;
    localparam logic [1:0] RO_MIMPID    = 2'd3;

    // Bit positions in mstatus, and in mip and mie.
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int IRQ_MSI      = 3;
    localparam int IRQ_MTI      = 7;

    // Fixed identity values.
    localparam logic [XLEN-1:0] VENDOR_ID = 64'h0000_0000_0000_0a5c;
    localparam logic [XLEN-1:0] ARCH_ID   = 64'h0000_0000_0000_0017;
    localparam logic [XLEN-1:0] IMP_ID    = 64'h0000_0000_0001_0200;

    // Interrupt cause codes, top bit marks an interrupt.
    localparam logic [XLEN-1:0] CAUSE_MSI = {1'b1, {(XLEN-4){1'b0}}, 3'd3};
    localparam logic [XLEN-1:0] CAUSE_MTI = {1'b1, {(XLEN-4){1'b0}}, 3'd7};

    typedef enum logic [1:0] {
        CSR_RW,
        CSR_RS,
        CSR_RC,
        CSR_MRET
    } csr_op_e;

    typedef struct packed {
        csr_op_e           op;
        logic [11:0]       addr;
        logic [XLEN-1:0]   wdata;   // Operand or mask.
    } csr_req_t;

    typedef struct packed {
        logic [XLEN-1:0]   rdata;
        logic              illegal;
    } csr_rsp_t;

    typedef struct packed {
        logic              en;
        logic [2:0]        slot;
        logic [XLEN-1:0]   data;
    } csr_wr_t;

    typedef struct packed {
        logic              mstatus_mie;
        logic              mtip;
        logic              msip;
        logic              mtie;
        logic              msie;
    } csr_irq_t;

endpackage

`default_nettype wire

/* logic/csr_file.sv */
// -------------------------------------------------------------------------
// Machine-mode CSR array with two write ports, hardware updates of the
// pending bits in mip, MIE/MPIE stacking on trap entry and MRET, the
// read-only identity registers and the interrupt status outputs.
// -------------------------------------------------------------------------
`default_nettype none

module csr_file #(
    parameter logic [csr_pkg::XLEN-1:0] HART_ID = '0
) (
    input  wire logic                     clk,
    input  wire logic                     arst,
    input  wire csr_pkg::csr_wr_t         i_wr_1,
    input  wire csr_pkg::csr_wr_t         i_wr_2,
    input  wire logic [2:0]               i_read_slot,
    input  wire logic                     i_writable,
    input  wire logic                     i_timer_irq,
    input  wire logic                     i_soft_irq,
    input  wire logic                     i_interrupt_jump,
    input  wire logic                     i_mret,
    output logic [csr_pkg::XLEN-1:0]      o_read_data,
    output csr_pkg::csr_irq_t             o_irq,
    output logic [csr_pkg::XLEN-1:0]      o_mtvec
);

    import csr_pkg::*;

    logic [XLEN-1:0] mem [8];
    logic [XLEN-1:0] ro_data;

    // Software writes never override the lines that own the pending bits,
    // and a trap taken in the same cycle wins over a written MIE.
    function automatic logic [XLEN-1:0] merge_write(input csr_wr_t wr);
        logic [XLEN-1:0] d;
        d = wr.data;
        if (wr.slot == SLOT_MIP) begin
            d[IRQ_MTI] = i_timer_irq;
            d[IRQ_MSI] = i_soft_irq;
        end
        if (wr.slot == SLOT_MSTATUS && i_interrupt_jump) begin
            d[MSTATUS_MIE] = 1'b0;
        end
        return d;
    endfunction

    // ---------------------------------------------------------------------
    // Register updates.
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            for (int i = 0; i < 8; i++) begin
                mem[i] <= '0;
            end
        end else begin
            mem[SLOT_MIP][IRQ_MTI] <= i_timer_irq;     // Pending bits track lines.
            mem[SLOT_MIP][IRQ_MSI] <= i_soft_irq;

            if (i_interrupt_jump) begin
                mem[SLOT_MSTATUS][MSTATUS_MIE]  <= 1'b0;
                mem[SLOT_MSTATUS][MSTATUS_MPIE] <= mem[SLOT_MSTATUS][MSTATUS_MIE];
            end

            if (i_mret) begin
                mem[SLOT_MSTATUS][MSTATUS_MIE] <= mem[SLOT_MSTATUS][MSTATUS_MPIE];
            end

            if (i_wr_1.en) begin
                mem[i_wr_1.slot] <= merge_write(i_wr_1);   // Access unit.
            end
            if (i_wr_2.en) begin
                mem[i_wr_2.slot] <= merge_write(i_wr_2);   // Trap unit.
            end
        end
    end

    // ---------------------------------------------------------------------
    // Read side.
    // ---------------------------------------------------------------------
    always_comb begin
        case (i_read_slot[1:0])
            RO_MHARTID:   ro_data = HART_ID;
            RO_MVENDORID: ro_data = VENDOR_ID;
            RO_MARCHID:   ro_data = ARCH_ID;
            RO_MIMPID:    ro_data = IMP_ID;
            default:      ro_data = '0;
        endcase
    end

    assign o_read_data = i_writable ? mem[i_read_slot] : ro_data;
    assign o_mtvec     = mem[SLOT_MTVEC];

    assign o_irq = '{
        mstatus_mie: mem[SLOT_MSTATUS][MSTATUS_MIE],
        mtip:        mem[SLOT_MIP][IRQ_MTI],
        msip:        mem[SLOT_MIP][IRQ_MSI],
        mtie:        mem[SLOT_MIE][IRQ_MTI],
        msie:        mem[SLOT_MIE][IRQ_MSI]
    };

    // The busy interlock between the two units keeps their writes apart.
    a_no_slot_clash: assert property (
        @(posedge clk) disable iff (arst)
        !(i_wr_1.en && i_wr_2.en && i_wr_1.slot == i_wr_2.slot)
    );

endmodule

`default_nettype wire

/* logic/csr_access_unit.sv */
// -------------------------------------------------------------------------
// Four-phase req/ack front end for CSRRW, CSRRS, CSRRC and MRET. Decodes
// the CSR address, performs the read-modify-write on the accept edge and
// flags unknown addresses and writes to read-only registers.
// -------------------------------------------------------------------------
`default_nettype none

module csr_access_unit (
    input  wire logic                     clk,
    input  wire logic                     arst,
    input  wire logic                     i_req,
    input  wire csr_pkg::csr_req_t        i_req_data,
    input  wire logic                     i_trap_busy,
    input  wire logic [csr_pkg::XLEN-1:0] i_read_data,
    output logic                          o_ack,
    output csr_pkg::csr_rsp_t             o_rsp,
    output logic [2:0]                    o_read_slot,
    output logic                          o_writable,
    output csr_pkg::csr_wr_t              o_wr,
    output logic                          o_mret,
    output logic                          o_busy
);

    import csr_pkg::*;

    logic            known;
    logic            wants_write;
    logic            illegal;
    logic            accept;
    logic [XLEN-1:0] new_value;

    // ---------------------------------------------------------------------
    // Address decode.
    // ---------------------------------------------------------------------
    always_comb begin
        o_read_slot = SLOT_MSTATUS;
        o_writable  = 1'b1;
        known       = 1'b1;
        case (i_req_data.addr)
            ADDR_MSTATUS:  o_read_slot = SLOT_MSTATUS;
            ADDR_MIE:      o_read_slot = SLOT_MIE;
            ADDR_MTVEC:    o_read_slot = SLOT_MTVEC;
            ADDR_MSCRATCH: o_read_slot = SLOT_MSCRATCH;
            ADDR_MEPC:     o_read_slot = SLOT_MEPC;
            ADDR_MCAUSE:   o_read_slot = SLOT_MCAUSE;
            ADDR_MIP:      o_read_slot = SLOT_MIP;
            ADDR_MHARTID: begin
                o_read_slot = {1'b0, RO_MHARTID};
                o_writable  = 1'b0;
            end
            ADDR_MVENDORID: begin
                o_read_slot = {1'b0, RO_MVENDORID};
                o_writable  = 1'b0;
            end
            ADDR_MARCHID: begin
                o_read_slot = {1'b0, RO_MARCHID};
                o_writable  = 1'b0;
            end
            ADDR_MIMPID: begin
                o_read_slot = {1'b0, RO_MIMPID};
                o_writable  = 1'b0;
            end
            default:       known = 1'b0;
        endcase
        if (i_req_data.op == CSR_MRET) begin
            o_read_slot = SLOT_MEPC;                // MRET ignores the address.
            o_writable  = 1'b1;
            known       = 1'b1;
        end
    end

    // ---------------------------------------------------------------------
    // Read-modify-write.
    // ---------------------------------------------------------------------
    always_comb begin
        case (i_req_data.op)
            CSR_RW:  new_value = i_req_data.wdata;
            CSR_RS:  new_value = i_read_data | i_req_data.wdata;
            CSR_RC:  new_value = i_read_data & ~i_req_data.wdata;
            default: new_value = i_read_data;
        endcase
    end

    assign wants_write = (i_req_data.op == CSR_RW) ||
                         ((i_req_data.op != CSR_MRET) && (i_req_data.wdata != '0));
    assign illegal     = !known || (!o_writable && wants_write);
    assign accept      = i_req && !o_ack && !i_trap_busy;

    // The write lands on the same edge that raises o_ack.
    assign o_wr.en   = accept && wants_write && !illegal;
    assign o_wr.slot = o_read_slot;
    assign o_wr.data = new_value;
    assign o_mret    = accept && (i_req_data.op == CSR_MRET);
    assign o_busy    = accept || o_ack;

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            o_ack <= 1'b0;
        end else if (accept) begin
            o_ack <= 1'b1;
        end else if (!i_req) begin
            o_ack <= 1'b0;                          // Requester dropped i_req.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_rsp.rdata   <= illegal ? '0 : i_read_data;
            o_rsp.illegal <= illegal;
        end
    end

    // The requester holds i_req until it sees o_ack.
    a_req_held_until_ack: assert property (
        @(posedge clk) disable iff (arst)
        $fell(i_req) |-> o_ack
    );

endmodule

`default_nettype wire

/* logic/trap_unit.sv */
// -------------------------------------------------------------------------
// Interrupt arbitration and trap entry. Picks the software interrupt
// before the timer, writes mcause and then mepc, and reports the handler
// address from mtvec for one cycle.
// -------------------------------------------------------------------------
`default_nettype none

module trap_unit (
    input  wire logic                     clk,
    input  wire logic                     arst,
    input  wire csr_pkg::csr_irq_t        i_irq,
    input  wire logic [csr_pkg::XLEN-1:0] i_mtvec,
    input  wire logic [csr_pkg::XLEN-1:0] i_pc,
    input  wire logic                     i_busy,
    output csr_pkg::csr_wr_t              o_wr,
    output logic                          o_interrupt_jump,
    output logic                          o_trap_busy,
    output logic                          o_trap_valid,
    output logic [csr_pkg::XLEN-1:0]      o_trap_pc
);

    import csr_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MEPC,
        S_REPORT
    } trap_state_e;

    trap_state_e     state_q;
    logic            msi_take;
    logic            mti_take;
    logic            take;
    logic [XLEN-1:0] pc_q;

    assign msi_take = i_irq.msip && i_irq.msie;
    assign mti_take = i_irq.mtip && i_irq.mtie;
    assign take     = (state_q == S_IDLE) && !i_busy && i_irq.mstatus_mie &&
                      (msi_take || mti_take);

    // ---------------------------------------------------------------------
    // Sequence control.
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE:   if (take) state_q <= S_MEPC;     // T0, mcause written.
                S_MEPC:   state_q <= S_REPORT;             // T1, mepc written.
                default:  state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_q <= i_pc;
        end
    end

    // ---------------------------------------------------------------------
    // CSR write port.
    // ---------------------------------------------------------------------
    always_comb begin
        o_wr.en   = 1'b0;
        o_wr.slot = SLOT_MCAUSE;
        o_wr.data = msi_take ? CAUSE_MSI : CAUSE_MTI;  // Software wins.
        if (take) begin
            o_wr.en = 1'b1;
        end else if (state_q == S_MEPC) begin
            o_wr.en   = 1'b1;
            o_wr.slot = SLOT_MEPC;
            o_wr.data = pc_q;
        end
    end

    assign o_interrupt_jump = take;
    assign o_trap_busy      = (state_q != S_IDLE);
    assign o_trap_valid     = (state_q == S_REPORT);
    assign o_trap_pc        = {i_mtvec[XLEN-1:2], 2'b00};  // Direct mode only.

    // One report cycle, and MIE cleared at T0 keeps a new entry from following.
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (arst)
        o_trap_valid |=> !o_trap_valid && !o_interrupt_jump
    );

endmodule

`default_nettype wire

/* logic/csr_subsystem_top.sv */
// -------------------------------------------------------------------------
// Top level of the machine-mode CSR block. Connects the access unit, the
// trap unit and the CSR file.
// -------------------------------------------------------------------------
`default_nettype none

module csr_subsystem_top #(
    parameter logic [csr_pkg::XLEN-1:0] HART_ID = '0
) (
    input  wire logic                     clk,
    input  wire logic                     arst,
    input  wire logic                     i_req,
    input  wire csr_pkg::csr_req_t        i_req_data,
    output logic                          o_ack,
    output csr_pkg::csr_rsp_t             o_rsp,
    input  wire logic                     i_timer_irq,
    input  wire logic                     i_soft_irq,
    input  wire logic [csr_pkg::XLEN-1:0] i_pc,
    output logic                          o_trap_valid,
    output logic [csr_pkg::XLEN-1:0]      o_trap_pc
);

    import csr_pkg::*;

    csr_wr_t         wr_access;
    csr_wr_t         wr_trap;
    csr_irq_t        irq;
    logic [2:0]      read_slot;
    logic            writable;
    logic [XLEN-1:0] read_data;
    logic [XLEN-1:0] mtvec;
    logic            mret;
    logic            interrupt_jump;
    logic            busy;
    logic            trap_busy;

    csr_access_unit access_i (
        .clk         (clk),
        .arst        (arst),
        .i_req       (i_req),
        .i_req_data  (i_req_data),
        .i_trap_busy (trap_busy),
        .i_read_data (read_data),
        .o_ack       (o_ack),
        .o_rsp       (o_rsp),
        .o_read_slot (read_slot),
        .o_writable  (writable),
        .o_wr        (wr_access),
        .o_mret      (mret),
        .o_busy      (busy)
    );

    trap_unit trap_i (
        .clk              (clk),
        .arst             (arst),
        .i_irq            (irq),
        .i_mtvec          (mtvec),
        .i_pc             (i_pc),
        .i_busy           (busy),
        .o_wr             (wr_trap),
        .o_interrupt_jump (interrupt_jump),
        .o_trap_busy      (trap_busy),
        .o_trap_valid     (o_trap_valid),
        .o_trap_pc        (o_trap_pc)
    );

    csr_file #(
        .HART_ID (HART_ID)
    ) file_i (
        .clk              (clk),
        .arst             (arst),
        .i_wr_1           (wr_access),
        .i_wr_2           (wr_trap),
        .i_read_slot      (read_slot),
        .i_writable       (writable),
        .i_timer_irq      (i_timer_irq),
        .i_soft_irq       (i_soft_irq),
        .i_interrupt_jump (interrupt_jump),
        .i_mret           (mret),
        .o_read_data      (read_data),
        .o_irq            (irq),
        .o_mtvec          (mtvec)
    );

endmodule

`default_nettype wire

/* bench/csr_tb_tasks.svh */
// -------------------------------------------------------------------------
// Testbench helpers: failure stop, cycle waits, the LFSR, the four-phase
// CSR transaction with its read and write wrappers, and the compare tasks.
// -------------------------------------------------------------------------
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

task automatic fail_now(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error.");
endtask

// Each wait ends at the drive point, 1 ns after a rising edge.
task automatic wait_cycles(input int n);
    repeat (n) begin
        @(posedge clk);
        #1;
    end
endtask

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic random_word(output logic [XLEN-1:0] v);
    for (int i = 0; i < XLEN; i++) begin
        lfsr_state = lfsr_step(lfsr_state);     // One step per bit.
        v[i] = lfsr_state[0];
    end
endtask

task automatic compare_rsp(input string name, input csr_rsp_t got, input csr_rsp_t exp);
    if (got !== exp) begin
        fail_now($sformatf("Mismatch at %0t: %s rdata=%h illegal=%b, expected rdata=%h illegal=%b",
                           $time, name, got.rdata, got.illegal, exp.rdata, exp.illegal));
    end
endtask

task automatic compare_data(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
        fail_now($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_now($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
endtask

task automatic csr_access(input csr_op_e op, input logic [11:0] addr,
                          input logic [XLEN-1:0] wdata, output csr_rsp_t rsp);
    int waited;
    waited = 0;
    i_req_data = '{op: op, addr: addr, wdata: wdata};
    i_req      = 1'b1;
    do begin
        wait_cycles(1);
        waited++;
        if (waited > ACK_LIMIT) begin
            fail_now("The DUT never raised o_ack for a CSR request.");
        end
    end while (!o_ack);
    rsp   = o_rsp;
    i_req = 1'b0;                               // Second half of the handshake.
    do begin
        wait_cycles(1);
        waited++;
        if (waited > ACK_LIMIT) begin
            fail_now("The DUT kept o_ack high after i_req fell.");
        end
    end while (o_ack);
endtask

task automatic read_csr(input logic [11:0] addr, output logic [XLEN-1:0] value);
    csr_rsp_t rsp;
    csr_access(CSR_RS, addr, '0, rsp);          // Zero mask, no write.
    compare_bit("o_rsp.illegal on read", rsp.illegal, 1'b0);
    value = rsp.rdata;
endtask

task automatic write_csr(input logic [11:0] addr, input logic [XLEN-1:0] value);
    csr_rsp_t rsp;
    csr_access(CSR_RW, addr, value, rsp);
    compare_bit("o_rsp.illegal on write", rsp.illegal, 1'b0);
endtask

task automatic check_csr(input string name, input logic [11:0] addr,
                         input logic [XLEN-1:0] exp);
    logic [XLEN-1:0] value;
    read_csr(addr, value);
    compare_data(name, value, exp);
endtask

`endif

/* bench/csr_subsystem_tb.sv */
// -------------------------------------------------------------------------
// Testbench for the machine-mode CSR block: clock, reset, DUT, trap pulse
// monitor, watchdog and the directed tests for CSR access, illegal
// accesses, pending lines, trap entry, priority and MRET.
// -------------------------------------------------------------------------
`default_nettype none

module csr_subsystem_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    localparam logic [XLEN-1:0] HART_ID = '0;
    localparam int NUM_TRANSACTIONS     = 55;
    localparam int WATCHDOG_CYCLES      = NUM_TRANSACTIONS * 20 + 300;
    localparam int ACK_LIMIT            = 20;
    localparam logic [XLEN-1:0] MTI_CODE = 64'h8000_0000_0000_0007;
    localparam logic [XLEN-1:0] MSI_CODE = 64'h8000_0000_0000_0003;

    logic            clk;
    logic            arst;
    logic            i_req;
    csr_req_t        i_req_data;
    logic            o_ack;
    csr_rsp_t        o_rsp;
    logic            i_timer_irq;
    logic            i_soft_irq;
    logic [XLEN-1:0] i_pc;
    logic            o_trap_valid;
    logic [XLEN-1:0] o_trap_pc;

    logic [31:0]     lfsr_state = 32'haabb356d;
    int              trap_count = 0;
    logic [XLEN-1:0] last_trap_pc;
    logic [XLEN-1:0] shadow_mscratch = '0;
    logic [XLEN-1:0] shadow_mtvec = '0;
    logic [XLEN-1:0] saved_pc;

    `include "csr_tb_tasks.svh"

    csr_subsystem_top #(
        .HART_ID (HART_ID)
    ) dut_i (
        .clk          (clk),
        .arst         (arst),
        .i_req        (i_req),
        .i_req_data   (i_req_data),
        .o_ack        (o_ack),
        .o_rsp        (o_rsp),
        .i_timer_irq  (i_timer_irq),
        .i_soft_irq   (i_soft_irq),
        .i_pc         (i_pc),
        .o_trap_valid (o_trap_valid),
        .o_trap_pc    (o_trap_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Pulses are counted mid-cycle, where o_trap_valid is settled.
    always @(negedge clk) begin
        if (o_trap_valid === 1'b1) begin
            trap_count   = trap_count + 1;
            last_trap_pc = o_trap_pc;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_now($sformatf("Watchdog expired after %0d cycles.", WATCHDOG_CYCLES));
    end

    // ---------------------------------------------------------------------
    // Test steps.
    // ---------------------------------------------------------------------
    task automatic wait_for_trap(input int base);
        int waited;
        waited = 0;
        while (trap_count == base) begin
            wait_cycles(1);
            waited++;
            if (waited > ACK_LIMIT) begin
                fail_now("No o_trap_valid pulse after an enabled pending interrupt.");
            end
        end
    endtask

    task automatic expect_traps(input int base, input int n);
        if (trap_count != base + n) begin
            fail_now($sformatf("Expected %0d trap pulses, saw %0d.", n, trap_count - base));
        end
    endtask

    task automatic check_writable_csrs();
        check_csr("mstatus", ADDR_MSTATUS, '0);
        check_csr("mie", ADDR_MIE, '0);
        check_csr("mtvec", ADDR_MTVEC, shadow_mtvec);
        check_csr("mscratch", ADDR_MSCRATCH, shadow_mscratch);
        check_csr("mepc", ADDR_MEPC, '0);
        check_csr("mcause", ADDR_MCAUSE, '0);
        check_csr("mip", ADDR_MIP, '0);
    endtask

    task automatic rmw_step(input string name, input logic [11:0] addr, input csr_op_e op,
                            input logic [XLEN-1:0] operand, inout logic [XLEN-1:0] model);
        csr_rsp_t rsp;
        csr_rsp_t exp;
        csr_access(op, addr, operand, rsp);
        exp = '{rdata: model, illegal: 1'b0};
        compare_rsp({name, " old value"}, rsp, exp);
        case (op)
            CSR_RW:  model = operand;
            CSR_RS:  model = model | operand;
            CSR_RC:  model = model & ~operand;
            default: model = model;
        endcase
        check_csr(name, addr, model);
    endtask

    task automatic rmw_sequence(input string name, input logic [11:0] addr,
                                inout logic [XLEN-1:0] model);
        logic [XLEN-1:0] operand;
        random_word(operand);
        rmw_step(name, addr, CSR_RW, operand, model);
        random_word(operand);
        rmw_step(name, addr, CSR_RS, operand, model);
        random_word(operand);
        rmw_step(name, addr, CSR_RC, operand, model);
        rmw_step(name, addr, CSR_RS, '0, model);            // Zero mask keeps the value.
    endtask

    task automatic test_illegal_access();
        csr_rsp_t        rsp;
        csr_rsp_t        exp;
        logic [XLEN-1:0] operand;
        exp = '{rdata: '0, illegal: 1'b1};
        random_word(operand);
        csr_access(CSR_RW, 12'h7C0, operand, rsp);          // Unused address.
        compare_rsp("unknown address", rsp, exp);
        csr_access(CSR_RW, ADDR_MVENDORID, operand, rsp);
        compare_rsp("mvendorid write", rsp, exp);
        csr_access(CSR_RS, ADDR_MVENDORID, operand | 64'h1, rsp);
        compare_rsp("mvendorid set", rsp, exp);
        check_csr("mvendorid", ADDR_MVENDORID, VENDOR_ID);
        check_writable_csrs();
    endtask

    task automatic test_pending_lines();
        logic [XLEN-1:0] value;
        int              base;
        base        = trap_count;
        i_timer_irq = 1'b1;
        i_soft_irq  = 1'b1;
        wait_cycles(1);
        read_csr(ADDR_MIP, value);
        compare_bit("mip.MTIP", value[7], 1'b1);
        compare_bit("mip.MSIP", value[3], 1'b1);
        write_csr(ADDR_MIE, 64'h88);                        // Enabled, MIE still 0.
        wait_cycles(4);
        write_csr(ADDR_MIE, '0);
        write_csr(ADDR_MSTATUS, 64'h8);                     // MIE set, none enabled.
        wait_cycles(4);
        write_csr(ADDR_MSTATUS, '0);
        compare_bit("trap taken while masked", trap_count != base, 1'b0);
        i_timer_irq = 1'b0;
        i_soft_irq  = 1'b0;
        wait_cycles(1);
        check_csr("mip", ADDR_MIP, '0);
    endtask

    task automatic test_trap_entry();
        logic [XLEN-1:0] handler;
        logic [XLEN-1:0] value;
        int              base;
        random_word(handler);
        random_word(saved_pc);
        write_csr(ADDR_MTVEC, handler);
        write_csr(ADDR_MIE, 64'h80);                        // MTIE only.
        write_csr(ADDR_MSTATUS, 64'h8);
        i_pc        = saved_pc;
        base        = trap_count;
        i_timer_irq = 1'b1;
        wait_for_trap(base);
        wait_cycles(6);
        expect_traps(base, 1);                              // Line still high, MIE now 0.
        compare_data("o_trap_pc", last_trap_pc, {handler[XLEN-1:2], 2'b00});
        check_csr("mcause", ADDR_MCAUSE, MTI_CODE);
        check_csr("mepc", ADDR_MEPC, saved_pc);
        read_csr(ADDR_MSTATUS, value);
        compare_bit("mstatus.MIE", value[3], 1'b0);
        compare_bit("mstatus.MPIE", value[7], 1'b1);
        i_timer_irq = 1'b0;
        wait_cycles(2);
    endtask

    task automatic test_mret();
        csr_rsp_t        rsp;
        csr_rsp_t        exp;
        logic [XLEN-1:0] value;
        csr_access(CSR_MRET, '0, '0, rsp);
        exp = '{rdata: saved_pc, illegal: 1'b0};
        compare_rsp("MRET", rsp, exp);
        read_csr(ADDR_MSTATUS, value);
        compare_bit("mstatus.MIE", value[3], 1'b1);
        compare_bit("mstatus.MPIE", value[7], 1'b1);
    endtask

    task automatic test_priority();
        logic [XLEN-1:0] pc;
        int              base;
        random_word(pc);
        i_pc = pc;
        write_csr(ADDR_MIE, 64'h88);
        base        = trap_count;
        i_timer_irq = 1'b1;
        i_soft_irq  = 1'b1;
        wait_for_trap(base);
        check_csr("mcause", ADDR_MCAUSE, MSI_CODE);         // Software before timer.
        check_csr("mepc", ADDR_MEPC, pc);
        i_timer_irq = 1'b0;
        i_soft_irq  = 1'b0;
        wait_cycles(4);
        expect_traps(base, 1);
    endtask

    // ---------------------------------------------------------------------
    // Main sequence.
    // ---------------------------------------------------------------------
    initial begin
        arst        = 1'b1;
        i_req       = 1'b0;
        i_req_data  = '0;
        i_timer_irq = 1'b0;
        i_soft_irq  = 1'b0;
        i_pc        = '0;
        repeat (3) @(posedge clk);
        #1;
        arst = 1'b0;

        check_writable_csrs();
        check_csr("mhartid", ADDR_MHARTID, HART_ID);
        check_csr("mvendorid", ADDR_MVENDORID, VENDOR_ID);
        check_csr("marchid", ADDR_MARCHID, ARCH_ID);
        check_csr("mimpid", ADDR_MIMPID, IMP_ID);
        rmw_sequence("mscratch", ADDR_MSCRATCH, shadow_mscratch);
        rmw_sequence("mtvec", ADDR_MTVEC, shadow_mtvec);
        test_illegal_access();
        test_pending_lines();
        test_trap_entry();
        test_mret();
        test_priority();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* csr_subsystem_top.f */
+incdir+bench
logic/csr_pkg.sv
logic/csr_file.sv
logic/csr_access_unit.sv
logic/trap_unit.sv
logic/csr_subsystem_top.sv
bench/csr_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the CSR block testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f csr_subsystem_top.f --top-module csr_subsystem_tb \
    -Mdir obj_dir -o csr_subsystem_sim > build.log 2>&1 \
    && ./obj_dir/csr_subsystem_sim > sim.log 2>&1 \
    || echo "Build or simulation returned an error, see build.log and sim.log"
grep -q "Simulation finished: PASS" sim.log && echo "Run passed" \
    || { echo "Run failed"; exit 1; }
